// ==== src/memc_pkg.sv ====
package memc_pkg;

    // frame geometry
    localparam int frame_width  = 64;
    localparam int frame_height = 48;
    localparam int block_size   = 8;

    // only the interior block columns are matched
    localparam int first_block_col   = 1;
    localparam int num_search_blocks = 6;

    // candidate k tests horizontal offset min_offset + k
    localparam int num_candidates = 4;
    localparam int min_offset     = -2;

    localparam int qpixel_bits   = 3;
    localparam int mvs_per_frame = 48;

    typedef logic [7:0] pixel_t;
    typedef logic [qpixel_bits-1:0] qpixel_t;

    typedef logic [$clog2(frame_width)-1:0]  col_t;
    typedef logic [$clog2(frame_height)-1:0] row_t;

    // 64 differences of at most 7 need 9 bits
    typedef logic [8:0] sad_t;

    typedef logic [$clog2(num_candidates)-1:0] cand_t;

    // upper nibble vertical (always 0), lower nibble horizontal offset
    typedef logic [7:0] mv_t;

    typedef logic [$clog2(mvs_per_frame)-1:0] mv_addr_t;

    typedef enum logic {
        sel_idle,
        sel_emit
    } sel_state_t;

endpackage

// ==== src/pixel_scan.sv ====
`timescale 1ns/10ps

module pixel_scan (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pixel_valid,
    input  memc_pkg::pixel_t  pixel,
    output memc_pkg::qpixel_t q_pixel,
    output memc_pkg::col_t    col,
    output memc_pkg::row_t    row,
    output logic              ref_write,
    output logic              search_valid,
    output logic              block_row_end
);

    // raster position of the next incoming pixel
    memc_pkg::col_t scan_col;
    memc_pkg::row_t scan_row;
    logic           ref_loaded;
    logic           last_col;
    logic           last_row;
    logic           block_last_row;

    assign last_col = (scan_col == memc_pkg::col_t'(memc_pkg::frame_width - 1));
    assign last_row = (scan_row == memc_pkg::row_t'(memc_pkg::frame_height - 1));
    assign block_last_row = (scan_row[2:0] == 3'(memc_pkg::block_size - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_col <= '0;
            scan_row <= '0;
        end else if (pixel_valid) begin
            if (last_col) begin
                scan_col <= '0;
                if (last_row) begin
                    scan_row <= '0;
                end else begin
                    scan_row <= scan_row + 1'b1;
                end
            end else begin
                scan_col <= scan_col + 1'b1;
            end
        end
    end

    // set once the last pixel of frame 0 has been taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_loaded <= 1'b0;
        end else if (pixel_valid && last_col && last_row) begin
            ref_loaded <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col           <= '0;
            row           <= '0;
            ref_write     <= 1'b0;
            search_valid  <= 1'b0;
            block_row_end <= 1'b0;
        end else begin
            ref_write     <= pixel_valid && !ref_loaded;
            search_valid  <= pixel_valid && ref_loaded;
            block_row_end <= pixel_valid && ref_loaded && last_col && block_last_row;
            if (pixel_valid) begin
                col <= scan_col;
                row <= scan_row;
            end
        end
    end

    // keep only the top bits
    always_ff @(posedge clk) begin
        q_pixel <= pixel[$bits(memc_pkg::pixel_t)-1 -: memc_pkg::qpixel_bits];
    end

endmodule

// ==== src/ref_frame_store.sv ====
`timescale 1ns/10ps

module ref_frame_store (
    input  logic              clk,
    input  logic              ref_write,
    input  memc_pkg::qpixel_t q_pixel,
    input  memc_pkg::col_t    col,
    input  memc_pkg::row_t    row,
    output memc_pkg::qpixel_t ref_taps [memc_pkg::num_candidates]
);

    localparam int depth = memc_pkg::frame_width * memc_pkg::frame_height;

    memc_pkg::qpixel_t mem [depth];

    always_ff @(posedge clk) begin
        if (ref_write) begin
            mem[int'(row) * memc_pkg::frame_width + int'(col)] <= q_pixel;
        end
    end

    // four neighbours on the same line, col-2 up to col+1
    // edge columns wrap within the line but are never matched
    for (genvar k = 0; k < memc_pkg::num_candidates; k++) begin : g_tap
        memc_pkg::col_t tap_col;

        assign tap_col = memc_pkg::col_t'(int'(col) + memc_pkg::min_offset + k);
        assign ref_taps[k] = mem[int'(row) * memc_pkg::frame_width + int'(tap_col)];
    end

endmodule

// ==== src/sad_accumulator.sv ====
`timescale 1ns/10ps

module sad_accumulator (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              search_valid,
    input  memc_pkg::qpixel_t q_pixel,
    input  memc_pkg::col_t    col,
    input  memc_pkg::qpixel_t ref_taps [memc_pkg::num_candidates],
    input  logic              block_row_end,
    output memc_pkg::sad_t    sums [memc_pkg::num_search_blocks][memc_pkg::num_candidates],
    output logic              sums_ready
);

    localparam int nb = memc_pkg::num_search_blocks;
    localparam int nc = memc_pkg::num_candidates;

    memc_pkg::qpixel_t abs_diff [nc];
    memc_pkg::sad_t    work [nb][nc];
    memc_pkg::sad_t    acc [nb][nc];
    memc_pkg::sad_t    hold [nb][nc];
    logic [2:0]        col_blk;
    logic              col_hit;
    logic              row_done;

    assign col_blk  = 3'(col / memc_pkg::block_size);
    assign col_hit  = (int'(col_blk) >= memc_pkg::first_block_col) &&
                      (int'(col_blk) < memc_pkg::first_block_col + nb);
    assign row_done = search_valid && block_row_end;

    always_comb begin
        for (int k = 0; k < nc; k++) begin
            if (q_pixel > ref_taps[k]) begin
                abs_diff[k] = q_pixel - ref_taps[k];
            end else begin
                abs_diff[k] = ref_taps[k] - q_pixel;
            end
        end
    end

    // only the block column under the current pixel collects its differences
    always_comb begin
        for (int b = 0; b < nb; b++) begin
            for (int k = 0; k < nc; k++) begin
                if (col_hit && (int'(col_blk) == b + memc_pkg::first_block_col)) begin
                    acc[b][k] = work[b][k] + memc_pkg::sad_t'(abs_diff[k]);
                end else begin
                    acc[b][k] = work[b][k];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < nb; b++) begin
                for (int k = 0; k < nc; k++) begin
                    work[b][k] <= '0;
                end
            end
            sums_ready <= 1'b0;
        end else begin
            sums_ready <= row_done;
            if (search_valid) begin
                for (int b = 0; b < nb; b++) begin
                    for (int k = 0; k < nc; k++) begin
                        work[b][k] <= row_done ? '0 : acc[b][k];
                    end
                end
            end
        end
    end

    // finished sums include the last pixel of the block row
    always_ff @(posedge clk) begin
        if (row_done) begin
            hold <= acc;
        end
    end

    assign sums = hold;

endmodule

// ==== src/mv_selector.sv ====
`timescale 1ns/10ps

module mv_selector (
    input  logic               clk,
    input  logic               rst_n,
    input  memc_pkg::sad_t     sums [memc_pkg::num_search_blocks][memc_pkg::num_candidates],
    input  logic               sums_ready,
    output logic               mv_valid,
    output memc_pkg::mv_t      mv,
    output memc_pkg::mv_addr_t mv_addr
);

    memc_pkg::sel_state_t state;
    logic [2:0]           blk_cnt;
    logic                 emit;
    logic                 last_blk;
    memc_pkg::cand_t      best_cand;
    memc_pkg::sad_t       best_sad;
    logic [3:0]           offset;
    memc_pkg::mv_addr_t   addr_cnt;

    assign emit     = (state == memc_pkg::sel_emit) || sums_ready;
    assign last_blk = (blk_cnt == 3'(memc_pkg::num_search_blocks - 1));

    // blk_cnt rests at 0 in idle so block 0 is searched in the sums_ready cycle
    // strict less-than keeps the first minimum in candidate order
    always_comb begin
        best_cand = '0;
        best_sad  = sums[blk_cnt][0];
        for (int k = 1; k < memc_pkg::num_candidates; k++) begin
            if (sums[blk_cnt][k] < best_sad) begin
                best_sad  = sums[blk_cnt][k];
                best_cand = memc_pkg::cand_t'(k);
            end
        end
    end

    assign offset = {2'b00, best_cand} + 4'(memc_pkg::min_offset);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= memc_pkg::sel_idle;
            blk_cnt  <= '0;
            mv_valid <= 1'b0;
            mv_addr  <= '0;
            addr_cnt <= '0;
        end else begin
            mv_valid <= emit;
            case (state)
                memc_pkg::sel_idle: begin
                    if (sums_ready) begin
                        state   <= memc_pkg::sel_emit;
                        blk_cnt <= 3'd1;
                    end
                end
                memc_pkg::sel_emit: begin
                    if (last_blk) begin
                        state   <= memc_pkg::sel_idle;
                        blk_cnt <= '0;
                    end else begin
                        blk_cnt <= blk_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= memc_pkg::sel_idle;
                end
            endcase
            if (emit) begin
                mv_addr <= addr_cnt;
                if (addr_cnt == memc_pkg::mv_addr_t'(memc_pkg::mvs_per_frame - 1)) begin
                    addr_cnt <= '0;
                end else begin
                    addr_cnt <= addr_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            mv <= memc_pkg::mv_t'({4'b0000, offset});
        end
    end

endmodule

// ==== src/memc_top.sv ====
`timescale 1ns/10ps

module memc_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pixel_valid,
    input  memc_pkg::pixel_t   pixel,
    output logic               mv_valid,
    output memc_pkg::mv_t      mv,
    output memc_pkg::mv_addr_t mv_addr
);

    memc_pkg::qpixel_t q_pixel;
    memc_pkg::col_t    col;
    memc_pkg::row_t    row;
    logic              ref_write;
    logic              search_valid;
    logic              block_row_end;
    logic              sums_ready;

    memc_pkg::qpixel_t ref_taps [memc_pkg::num_candidates];
    memc_pkg::sad_t    sums [memc_pkg::num_search_blocks][memc_pkg::num_candidates];

    pixel_scan u_pixel_scan (
        .clk           (clk),
        .rst_n         (rst_n),
        .pixel_valid   (pixel_valid),
        .pixel         (pixel),
        .q_pixel       (q_pixel),
        .col           (col),
        .row           (row),
        .ref_write     (ref_write),
        .search_valid  (search_valid),
        .block_row_end (block_row_end)
    );

    // frame 0 only, then fixed
    ref_frame_store u_ref_frame_store (
        .clk       (clk),
        .ref_write (ref_write),
        .q_pixel   (q_pixel),
        .col       (col),
        .row       (row),
        .ref_taps  (ref_taps)
    );

    sad_accumulator u_sad_accumulator (
        .clk           (clk),
        .rst_n         (rst_n),
        .search_valid  (search_valid),
        .q_pixel       (q_pixel),
        .col           (col),
        .ref_taps      (ref_taps),
        .block_row_end (block_row_end),
        .sums          (sums),
        .sums_ready    (sums_ready)
    );

    mv_selector u_mv_selector (
        .clk        (clk),
        .rst_n      (rst_n),
        .sums       (sums),
        .sums_ready (sums_ready),
        .mv_valid   (mv_valid),
        .mv         (mv),
        .mv_addr    (mv_addr)
    );

endmodule

// ==== verif/memc_ref.svh ====
`ifndef MEMC_REF_SVH
`define MEMC_REF_SVH

// keep the top bits of a raw pixel
function automatic memc_pkg::qpixel_t quantize(input memc_pkg::pixel_t p);
    return memc_pkg::qpixel_t'(p >> ($bits(memc_pkg::pixel_t) - memc_pkg::qpixel_bits));
endfunction

// horizontal offset as a sign-extended lower nibble, vertical nibble zero
function automatic memc_pkg::mv_t offset_to_mv(input int d);
    logic [3:0] nib;
    nib = 4'(d);
    return {4'b0000, nib};
endfunction

// current block against the reference moved right by d columns
function automatic int block_sad(input int br, input int bc, input int d);
    int sum;
    int a;
    int b;
    int idx;
    sum = 0;
    for (int y = br * memc_pkg::block_size; y < (br + 1) * memc_pkg::block_size; y++) begin
        for (int x = bc * memc_pkg::block_size; x < (bc + 1) * memc_pkg::block_size; x++) begin
            idx = y * memc_pkg::frame_width + x;
            a = int'(quantize(cur_frame[idx]));
            b = int'(quantize(ref_frame[idx + d]));
            sum += (a > b) ? a - b : b - a;
        end
    end
    return sum;
endfunction

// first minimum wins, candidates tried from the leftmost offset
function automatic memc_pkg::mv_t expected_mv(input int br, input int bc);
    int best_d;
    int best_sad;
    int s;
    best_d   = memc_pkg::min_offset;
    best_sad = block_sad(br, bc, best_d);
    for (int k = 1; k < memc_pkg::num_candidates; k++) begin
        s = block_sad(br, bc, memc_pkg::min_offset + k);
        if (s < best_sad) begin
            best_sad = s;
            best_d   = memc_pkg::min_offset + k;
        end
    end
    return offset_to_mv(best_d);
endfunction

`endif

// ==== verif/memc_tb.sv ====
`timescale 1ns/10ps

module memc_tb;

    localparam int clk_period      = 40;
    localparam int reset_cycles    = 10;
    localparam int seed            = 63;
    localparam int num_frames      = 13;
    localparam int gap_pct         = 25;
    localparam int drain_limit     = 64;
    localparam int frame_pixels    = memc_pkg::frame_width * memc_pkg::frame_height;
    localparam int watchdog_cycles = num_frames * frame_pixels * 2 + 2000;

    localparam int kind_random   = 0;
    localparam int kind_shift    = 1;
    localparam int kind_low_bits = 2;
    localparam int kind_few      = 3;
    localparam int kind_flat     = 4;

    logic               clk;
    logic               rst_n;
    logic               pixel_valid;
    memc_pkg::pixel_t   pixel;
    logic               mv_valid;
    memc_pkg::mv_t      mv;
    memc_pkg::mv_addr_t mv_addr;

    memc_pkg::pixel_t   ref_frame [frame_pixels];
    memc_pkg::pixel_t   cur_frame [frame_pixels];
    memc_pkg::mv_t      exp_mv [$];
    memc_pkg::mv_addr_t exp_addr [$];

    int next_addr;
    int error_count;
    int vectors_seen;
    int valid_count;
    int wrap_count;
    int last_addr;
    int tests_run;
    int tests_failed;
    int base_errors;
    int base_vectors;
    int base_wraps;

    `include "memc_ref.svh"

    memc_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .mv_valid    (mv_valid),
        .mv          (mv),
        .mv_addr     (mv_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the DUT stopped producing vectors",
                 watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    task automatic check_mv(input memc_pkg::mv_t got, input memc_pkg::mv_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: mv is %02h, expected %02h", $time, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(input memc_pkg::mv_addr_t got, input memc_pkg::mv_addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: mv_addr is %0d, expected %0d", $time, got, exp);
            error_count++;
        end
    endtask

    // outputs change on the rising edge, so the falling edge sees them settled
    initial begin
        last_addr = -1;
        forever begin
            @(negedge clk);
            if (mv_valid !== 1'b0) begin
                valid_count++;
                if (exp_mv.size() == 0) begin
                    $display("unexpected motion vector at %0t while none was pending", $time);
                    error_count++;
                end else begin
                    check_mv(mv, exp_mv.pop_front());
                    check_addr(mv_addr, exp_addr.pop_front());
                    vectors_seen++;
                end
                if (last_addr == memc_pkg::mvs_per_frame - 1 && mv_addr == '0) begin
                    wrap_count++;
                end
                last_addr = int'(mv_addr);
            end
        end
    end

    task automatic build_frame(input int kind, input int d);
        int idx;
        int src_col;
        for (int y = 0; y < memc_pkg::frame_height; y++) begin
            for (int x = 0; x < memc_pkg::frame_width; x++) begin
                idx = y * memc_pkg::frame_width + x;
                src_col = (x + d + memc_pkg::frame_width) % memc_pkg::frame_width;
                case (kind)
                    kind_shift: cur_frame[idx] = ref_frame[y * memc_pkg::frame_width + src_col];
                    kind_low_bits: cur_frame[idx] = {ref_frame[idx][7:5], 5'($urandom)};
                    kind_few: cur_frame[idx] = 8'(int'($urandom_range(2)) * 8'h40 + 8'h20);
                    kind_flat: cur_frame[idx] = 8'h6c;
                    default: cur_frame[idx] = memc_pkg::pixel_t'($urandom);
                endcase
            end
        end
    endtask

    // one vector per matched block, addresses run on across frames
    task automatic queue_vectors(input bit forced, input int d);
        for (int br = 0; br < memc_pkg::frame_height / memc_pkg::block_size; br++) begin
            for (int b = 0; b < memc_pkg::num_search_blocks; b++) begin
                if (forced) begin
                    exp_mv.push_back(offset_to_mv(d));
                end else begin
                    exp_mv.push_back(expected_mv(br, b + memc_pkg::first_block_col));
                end
                exp_addr.push_back(memc_pkg::mv_addr_t'(next_addr));
                next_addr = (next_addr + 1) % memc_pkg::mvs_per_frame;
            end
        end
    endtask

    task automatic send_frame(input int gap);
        for (int i = 0; i < frame_pixels; i++) begin
            while (int'($urandom_range(99)) < gap) begin
                @(negedge clk);
                pixel_valid = 1'b0;
                pixel       = memc_pkg::pixel_t'($urandom);
            end
            @(negedge clk);
            pixel_valid = 1'b1;
            pixel       = cur_frame[i];
        end
        @(negedge clk);
        pixel_valid = 1'b0;
    endtask

    task automatic run_search_frame(input int kind, input int d, input bit forced,
                                    input int gap);
        build_frame(kind, d);
        queue_vectors(forced, d);
        send_frame(gap);
    endtask

    task automatic drain_vectors();
        int waited;
        waited = 0;
        while (exp_mv.size() != 0 && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_mv.size() != 0) begin
            $display("%0d expected motion vectors never arrived", exp_mv.size());
            error_count++;
            exp_mv.delete();
            exp_addr.delete();
        end
    endtask

    task automatic start_test();
        base_errors  = error_count;
        base_vectors = vectors_seen;
        base_wraps   = wrap_count;
    endtask

    task automatic finish_test(input int num, input string name, input bit extra_ok);
        int errs;
        errs = error_count - base_errors;
        tests_run++;
        if (errs != 0 || !extra_ok) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d vectors, %0d errors", num, name,
                 (errs == 0 && extra_ok) ? "PASS" : "FAIL", vectors_seen - base_vectors, errs);
    endtask

    initial begin
        bit wrapped;
        rst_n       = 1'b0;
        pixel_valid = 1'b0;
        pixel       = '0;
        void'($urandom(seed));

        start_test();
        repeat (reset_cycles) @(negedge clk);
        check_addr(mv_addr, '0);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);
        build_frame(kind_random, 0);
        ref_frame = cur_frame;
        send_frame(0);
        repeat (drain_limit) @(negedge clk);
        finish_test(1, "reference frame gives no vectors", valid_count == 0);

        start_test();
        run_search_frame(kind_shift, 0, 1'b1, 0);
        drain_vectors();
        finish_test(2, "identical frame", 1'b1);

        start_test();
        for (int d = memc_pkg::min_offset; d < memc_pkg::min_offset + 4; d++) begin
            run_search_frame(kind_shift, d, 1'b1, 0);
            drain_vectors();
        end
        finish_test(3, "shifted frames", 1'b1);

        start_test();
        run_search_frame(kind_low_bits, 0, 1'b1, 0);
        drain_vectors();
        finish_test(4, "lower bits changed", 1'b1);

        // few distinct values make equal sums likely
        start_test();
        run_search_frame(kind_random, 0, 1'b0, 0);
        run_search_frame(kind_few, 0, 1'b0, 0);
        run_search_frame(kind_flat, 0, 1'b0, 0);
        drain_vectors();
        finish_test(5, "random and tie frames", 1'b1);

        start_test();
        run_search_frame(kind_shift, 0, 1'b1, gap_pct);
        run_search_frame(kind_random, 0, 1'b0, gap_pct);
        run_search_frame(kind_shift, -1, 1'b1, gap_pct);
        drain_vectors();
        wrapped = (wrap_count > base_wraps);
        if (!wrapped) begin
            $display("mv_addr never wrapped from 47 to 0 during the frames with gaps");
        end
        finish_test(6, "frames with input gaps", wrapped);

        repeat (drain_limit) @(negedge clk);
        $display("tests run %0d, tests failed %0d, vectors checked %0d, errors %0d",
                 tests_run, tests_failed, vectors_seen, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verif
src/memc_pkg.sv
src/pixel_scan.sv
src/ref_frame_store.sv
src/sad_accumulator.sv
src/mv_selector.sv
src/memc_top.sv
verif/memc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module memc_tb -f project.f -o memc_sim
./obj_dir/memc_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
